// File: design/ex_config_regs.sv
module ex_config_regs import ex_result_pkg::*; #(
	parameter int RETIRE_W = 16
) (
	input  logic        CLK,
	input  logic        rst,
	input  logic        psel,
	input  logic        penable,
	input  logic        pwrite,
	input  logic [3:0]  paddr,
	input  logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic        pready,
	input  logic        retire,
	output logic [31:0] fwd_flags
);

	localparam logic [3:0] ADDR_FLAGS   = 4'h0;
	localparam logic [3:0] ADDR_RETIRED = 4'h4;

	logic                flag_cf;
	logic                flag_af;
	logic                flag_df;
	logic [RETIRE_W-1:0] retired;
	logic                wr_en;
	logic                rd_setup;

	// no wait states
	assign pready = 1'b1;

	assign wr_en = psel & penable & pwrite;
	// read data is prepared in the setup cycle
	assign rd_setup = psel & ~penable & ~pwrite;

	// ------------------------------------------------------------
	// flag register and retire counter
	// ------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (rst) begin
			flag_cf <= 1'b0;
			flag_af <= 1'b0;
			flag_df <= 1'b0;
		end else if (wr_en && paddr == ADDR_FLAGS) begin
			flag_cf <= pwdata[FLAG_CF];
			flag_af <= pwdata[FLAG_AF];
			flag_df <= pwdata[FLAG_DF];
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			retired <= '0;
		end else if (retire) begin
			retired <= retired + 1'b1;
		end
	end

	always_comb begin
		fwd_flags = '0;
		fwd_flags[FLAG_CF] = flag_cf;
		fwd_flags[FLAG_AF] = flag_af;
		fwd_flags[FLAG_DF] = flag_df;
	end

	// ------------------------------------------------------------
	// read path
	// ------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (rst) begin
			prdata <= '0;
		end else if (rd_setup) begin
			case (paddr)
				ADDR_FLAGS:   prdata <= fwd_flags;
				ADDR_RETIRED: prdata <= 32'(retired);
				default:      prdata <= '0;
			endcase
		end
	end

endmodule

// File: design/ex_functional_unit.sv
module ex_functional_unit import ex_uop_pkg::*, ex_result_pkg::*; (
	input  ex_uop_t      uop,
	input  ex_operands_t ops,
	input  logic [31:0]  b_sel,
	input  logic [31:0]  count_sel,
	input  logic [31:0]  fwd_flags,
	output logic [31:0]  alu_result,
	output logic [31:0]  alu_flags,
	output logic [31:0]  shift_result,
	output logic [31:0]  shift_flags,
	output logic [31:0]  count_minus_one,
	output logic [31:0]  stack_pointer_pop,
	output logic [31:0]  cmps_pointer
);

	logic [32:0] alu_wide;
	logic        alu_cf;
	logic        alu_of;
	logic [32:0] shift_wide;
	logic        shift_cf;
	logic [4:0]  shamt;
	logic [31:0] step;

	// ------------------------------------------------------------
	// alu
	// ------------------------------------------------------------
	always_comb begin
		alu_cf = 1'b0;
		alu_of = 1'b0;
		case (uop.aluk)
			ALU_ADD: begin
				alu_wide = {1'b0, ops.a} + {1'b0, b_sel};
				alu_cf = alu_wide[32];
				alu_of = (ops.a[31] == b_sel[31]) && (alu_wide[31] != ops.a[31]);
			end
			ALU_SUB: begin
				// bit 32 is the borrow
				alu_wide = {1'b0, ops.a} - {1'b0, b_sel};
				alu_cf = alu_wide[32];
				alu_of = (ops.a[31] != b_sel[31]) && (alu_wide[31] != ops.a[31]);
			end
			ALU_AND:    alu_wide = {1'b0, ops.a & b_sel};
			ALU_OR:     alu_wide = {1'b0, ops.a | b_sel};
			ALU_XOR:    alu_wide = {1'b0, ops.a ^ b_sel};
			ALU_PASS_B: alu_wide = {1'b0, b_sel};
			default:    alu_wide = {1'b0, ops.a};
		endcase
	end

	assign alu_result = alu_wide[31:0];

	// AF and DF are not computed here, they come from the forwarded flags
	always_comb begin
		alu_flags = '0;
		alu_flags[FLAG_CF] = alu_cf;
		alu_flags[FLAG_AF] = fwd_flags[FLAG_AF];
		alu_flags[FLAG_ZF] = (alu_result == '0);
		alu_flags[FLAG_SF] = alu_result[31];
		alu_flags[FLAG_DF] = fwd_flags[FLAG_DF];
		alu_flags[FLAG_OF] = alu_of;
	end

	// ------------------------------------------------------------
	// shifter
	// ------------------------------------------------------------
	assign shamt = b_sel[4:0];

	always_comb begin
		if (uop.aluk == ALU_SHR) begin
			shift_wide = {ops.a, 1'b0} >> shamt;
			shift_result = shift_wide[32:1];
			shift_cf = shift_wide[0];
		end else begin
			shift_wide = {1'b0, ops.a} << shamt;
			shift_result = shift_wide[31:0];
			shift_cf = shift_wide[32];
		end
		// zero count leaves CF alone
		if (shamt == 5'd0) begin
			shift_cf = fwd_flags[FLAG_CF];
		end
	end

	always_comb begin
		shift_flags = '0;
		shift_flags[FLAG_CF] = shift_cf;
		shift_flags[FLAG_AF] = fwd_flags[FLAG_AF];
		shift_flags[FLAG_ZF] = (shift_result == '0);
		shift_flags[FLAG_DF] = fwd_flags[FLAG_DF];
	end

	// ------------------------------------------------------------
	// count and pointer adders
	// ------------------------------------------------------------
	assign step = dsize_step(uop.dsize);
	assign count_minus_one = count_sel - 32'd1;
	assign stack_pointer_pop = ops.c + step;
	// DF set walks the string downwards
	assign cmps_pointer = fwd_flags[FLAG_DF] ? (b_sel - step) : (b_sel + step);

endmodule

// File: design/ex_operand_select.sv
module ex_operand_select import ex_uop_pkg::*; (
	input  logic         CLK,
	input  logic         rst,
	input  logic         ex_v,
	input  logic         stall,
	input  ex_uop_t      uop,
	input  ex_operands_t ops,
	input  logic [31:0]  saved_count,
	output logic [31:0]  b_sel,
	output logic [31:0]  count_sel
);

	// A of the first cmps micro-op, consumed as B by the second
	logic [31:0] cmps_first_mem;
	logic        cmps_capture;

	// only a valid first micro-op that actually advances
	assign cmps_capture = ex_v & uop.cmps_first & ~stall;

	always_ff @(posedge CLK) begin
		if (rst) begin
			cmps_first_mem <= '0;
		end else if (cmps_capture) begin
			cmps_first_mem <= ops.a;
		end
	end

	// b operand
	always_comb begin
		if (uop.cmps_second) begin
			b_sel = cmps_first_mem;
		end else begin
			b_sel = ops.b;
		end
	end

	// repne keeps its count internally, the rest use C
	always_comb begin
		if (uop.repne) begin
			count_sel = saved_count;
		end else begin
			count_sel = ops.c;
		end
	end

endmodule

// File: design/ex_result_pkg.sv
package ex_result_pkg;

	// ------------------------------------------------------------
	// eflags bit positions
	// ------------------------------------------------------------
	parameter int FLAG_CF = 0;
	parameter int FLAG_AF = 4;
	parameter int FLAG_ZF = 6;
	parameter int FLAG_SF = 7;
	parameter int FLAG_DF = 10;
	parameter int FLAG_OF = 11;

	// ------------------------------------------------------------
	// writeback payload and control
	// ------------------------------------------------------------
	typedef struct packed {
		logic [31:0] result_a;
		logic [31:0] result_b;
		logic [31:0] result_c;
		logic [31:0] flags;
	} wb_result_t;

	// enables are already qualified by v
	typedef struct packed {
		logic v;
		logic ld_gpr1;
		logic ld_gpr2;
		logic dcache_write;
	} wb_ctrl_t;

endpackage

// File: design/ex_result_select.sv
module ex_result_select import ex_uop_pkg::*, ex_result_pkg::*; (
	input  ex_uop_t      uop,
	input  ex_operands_t ops,
	input  logic [31:0]  alu_result,
	input  logic [31:0]  alu_flags,
	input  logic [31:0]  shift_result,
	input  logic [31:0]  shift_flags,
	input  logic [31:0]  count_minus_one,
	input  logic [31:0]  stack_pointer_pop,
	input  logic [31:0]  cmps_pointer,
	output wb_result_t   result_next
);

	// ------------------------------------------------------------
	// lane a
	// ------------------------------------------------------------
	// first match wins, shifter is the fallback
	always_comb begin
		if (uop.is_alu32) begin
			result_next.result_a = alu_result;
		end else if (uop.mux_cmps_pointer) begin
			result_next.result_a = cmps_pointer;
		end else if (uop.cmps_first || uop.is_xchg) begin
			result_next.result_a = ops.b;
		end else if (uop.pass_a) begin
			result_next.result_a = ops.a;
		end else if (uop.is_cmpxchg) begin
			result_next.result_a = ops.c;
		end else begin
			result_next.result_a = shift_result;
		end
	end

	// ------------------------------------------------------------
	// lane b
	// ------------------------------------------------------------
	always_comb begin
		if (uop.mux_cmps_pointer) begin
			result_next.result_b = cmps_pointer;
		end else if (uop.alu_to_b) begin
			result_next.result_b = alu_result;
		end else if (uop.is_cmpxchg || uop.is_xchg) begin
			result_next.result_b = ops.a;
		end else begin
			result_next.result_b = ops.b;
		end
	end

	// ------------------------------------------------------------
	// lane c and flags
	// ------------------------------------------------------------
	// either half of the cmps pair decrements the count
	always_comb begin
		if (uop.cmps_first || uop.cmps_second) begin
			result_next.result_c = count_minus_one;
		end else if (uop.mux_sp_pop) begin
			result_next.result_c = stack_pointer_pop;
		end else begin
			result_next.result_c = ops.c;
		end
	end

	always_comb begin
		if (uop.alu32_flags) begin
			result_next.flags = alu_flags;
		end else begin
			result_next.flags = shift_flags;
		end
	end

endmodule

// File: design/ex_stage.sv
module ex_stage import ex_uop_pkg::*, ex_result_pkg::*; #(
	parameter int RETIRE_W = 16
) (
	input  logic         CLK,
	input  logic         rst,
	input  logic         ex_v,
	input  ex_uop_t      uop,
	input  ex_operands_t ops,
	input  logic [31:0]  saved_count,
	input  logic         wb_stall,
	input  logic         psel,
	input  logic         penable,
	input  logic         pwrite,
	input  logic [3:0]   paddr,
	input  logic [31:0]  pwdata,
	output logic [31:0]  prdata,
	output logic         pready,
	output wb_result_t   wb_result,
	output wb_ctrl_t     wb_ctrl,
	output logic         wb_ld_latches
);

	logic [31:0] fwd_flags;
	logic [31:0] b_sel;
	logic [31:0] count_sel;
	logic [31:0] alu_result;
	logic [31:0] alu_flags;
	logic [31:0] shift_result;
	logic [31:0] shift_flags;
	logic [31:0] count_minus_one;
	logic [31:0] stack_pointer_pop;
	logic [31:0] cmps_pointer;
	wb_result_t  result_next;
	wb_ctrl_t    ctrl_next;
	logic        retire;

	// counts once per loaded valid micro-op, never during a stall
	assign retire = wb_ld_latches & ctrl_next.v;

	// ------------------------------------------------------------
	// execute
	// ------------------------------------------------------------
	ex_operand_select u_operand_select (
		.CLK(CLK), .rst(rst), .ex_v(ex_v), .stall(wb_stall), .uop(uop), .ops(ops),
		.saved_count(saved_count), .b_sel(b_sel), .count_sel(count_sel)
	);

	ex_functional_unit u_functional_unit (
		.uop(uop), .ops(ops), .b_sel(b_sel), .count_sel(count_sel),
		.fwd_flags(fwd_flags), .alu_result(alu_result), .alu_flags(alu_flags),
		.shift_result(shift_result), .shift_flags(shift_flags),
		.count_minus_one(count_minus_one), .stack_pointer_pop(stack_pointer_pop),
		.cmps_pointer(cmps_pointer)
	);

	ex_writeback_control u_writeback_control (
		.ex_v(ex_v), .uop(uop), .count_sel(count_sel), .alu_zf(alu_flags[FLAG_ZF]),
		.wb_stall(wb_stall), .ctrl_next(ctrl_next), .ld_latches(wb_ld_latches)
	);

	ex_result_select u_result_select (
		.uop(uop), .ops(ops), .alu_result(alu_result), .alu_flags(alu_flags),
		.shift_result(shift_result), .shift_flags(shift_flags),
		.count_minus_one(count_minus_one), .stack_pointer_pop(stack_pointer_pop),
		.cmps_pointer(cmps_pointer), .result_next(result_next)
	);

	// ------------------------------------------------------------
	// ex to wb latches and config block
	// ------------------------------------------------------------
	ex_wb_latch #(.payload_t(wb_result_t)) u_result_latch (
		.CLK(CLK), .rst(rst), .ld(wb_ld_latches), .d(result_next), .q(wb_result)
	);

	ex_wb_latch #(.payload_t(wb_ctrl_t)) u_ctrl_latch (
		.CLK(CLK), .rst(rst), .ld(wb_ld_latches), .d(ctrl_next), .q(wb_ctrl)
	);

	ex_config_regs #(.RETIRE_W(RETIRE_W)) u_config_regs (
		.CLK(CLK), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.retire(retire), .fwd_flags(fwd_flags)
	);

endmodule

// File: design/ex_uop_pkg.sv
package ex_uop_pkg;

	// ------------------------------------------------------------
	// alu operation codes
	// ------------------------------------------------------------
	// shl and shr are handled by the shifter, not the alu
	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		ALU_PASS_B = 3'd5,
		ALU_SHL    = 3'd6,
		ALU_SHR    = 3'd7
	} aluk_e;

	// data size, only used for pointer and stack steps
	typedef enum logic [1:0] {
		DSIZE_BYTE  = 2'd0,
		DSIZE_WORD  = 2'd1,
		DSIZE_DWORD = 2'd2,
		DSIZE_QWORD = 2'd3
	} dsize_e;

	// ------------------------------------------------------------
	// decoded micro-op control
	// ------------------------------------------------------------
	typedef struct packed {
		aluk_e  aluk;
		dsize_e dsize;
		logic   is_alu32;
		logic   alu32_flags;
		logic   alu_to_b;
		logic   pass_a;
		logic   is_xchg;
		logic   is_cmpxchg;
		logic   cmps_first;
		logic   cmps_second;
		logic   mux_cmps_pointer;
		logic   mux_sp_pop;
		logic   repne;
		logic   ld_gpr1;
		logic   ld_gpr2;
		logic   dcache_write;
	} ex_uop_t;

	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
	} ex_operands_t;

	// step of 1, 2, 4 or 8 bytes
	function automatic logic [31:0] dsize_step(input dsize_e dsize);
		return 32'd1 << dsize;
	endfunction

endpackage

// File: design/ex_wb_latch.sv
module ex_wb_latch #(
	parameter type payload_t = logic [31:0]
) (
	input  logic     CLK,
	input  logic     rst,
	input  logic     ld,
	input  payload_t d,
	output payload_t q
);

	payload_t q_r;

	// holds its value whenever ld is low (wb stall)
	always_ff @(posedge CLK) begin
		if (rst) begin
			q_r <= '0;
		end else if (ld) begin
			q_r <= d;
		end
	end

	assign q = q_r;

endmodule

// File: design/ex_writeback_control.sv
module ex_writeback_control import ex_uop_pkg::*, ex_result_pkg::*; (
	input  logic        ex_v,
	input  ex_uop_t     uop,
	input  logic [31:0] count_sel,
	input  logic        alu_zf,
	input  logic        wb_stall,
	output wb_ctrl_t    ctrl_next,
	output logic        ld_latches
);

	logic v;
	logic gpr1;
	logic gpr2;
	logic dcache;

	// ------------------------------------------------------------
	// repne termination
	// ------------------------------------------------------------
	// zero count turns the micro-op into a bubble
	always_comb begin
		if (uop.repne) begin
			v = ex_v & (count_sel != '0);
		end else begin
			v = ex_v;
		end
	end

	// ------------------------------------------------------------
	// cmpxchg decision
	// ------------------------------------------------------------
	always_comb begin
		if (uop.is_cmpxchg) begin
			// equal: store to destination, else load accumulator
			gpr1 = uop.ld_gpr1 & alu_zf;
			gpr2 = ~alu_zf;
			dcache = uop.dcache_write & alu_zf;
		end else begin
			gpr1 = uop.ld_gpr1;
			gpr2 = uop.ld_gpr2;
			dcache = uop.dcache_write;
		end
	end

	// qualify every enable with v
	always_comb begin
		ctrl_next.v = v;
		ctrl_next.ld_gpr1 = v & gpr1;
		ctrl_next.ld_gpr2 = v & gpr2;
		ctrl_next.dcache_write = v & dcache;
	end

	assign ld_latches = ~wb_stall;

endmodule

// File: ex_stage.f
design/ex_uop_pkg.sv
design/ex_result_pkg.sv
design/ex_operand_select.sv
design/ex_functional_unit.sv
design/ex_writeback_control.sv
design/ex_result_select.sv
design/ex_wb_latch.sv
design/ex_config_regs.sv
design/ex_stage.sv
tests/ex_stage_assertions.sv
tests/ex_stage_tb.sv

// File: tests/ex_stage_assertions.sv
module ex_stage_assertions import ex_uop_pkg::*, ex_result_pkg::*; (
	input logic         CLK,
	input logic         rst,
	input logic         ex_v,
	input ex_uop_t      uop,
	input ex_operands_t ops,
	input logic [31:0]  saved_count,
	input logic         wb_stall,
	input logic         psel,
	input logic         penable,
	input logic         pwrite,
	input logic [3:0]   paddr,
	input logic [31:0]  pwdata,
	input wb_result_t   wb_result,
	input wb_ctrl_t     wb_ctrl,
	input logic         wb_ld_latches
);

	localparam logic [31:0] FLAG_MASK = (32'd1 << FLAG_CF) | (32'd1 << FLAG_AF) |
		(32'd1 << FLAG_DF);

	// expected outcome of one micro-op at its issue cycle
	typedef struct packed {
		ex_uop_t     uop;
		logic        v;
		logic        shift_op;
		logic        zf;
		logic        alu_cf;
		logic        alu_of;
		logic        shift_cf;
		logic [31:0] a;
		logic [31:0] alu;
		logic [31:0] shift;
		logic [31:0] ptr;
		logic [31:0] cnt;
		logic [31:0] pop;
	} expect_t;

	int          fail_count = 0;
	logic [31:0] flags_ref;
	logic [31:0] cmps_ref;
	logic [31:0] b_eff;
	logic [31:0] step;
	logic [4:0]  sh;
	logic [32:0] signed_sum;
	expect_t     cur;
	expect_t     prev;

	// ------------------------------------------------------------
	// reference state
	// ------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (rst) begin
			flags_ref <= '0;
			cmps_ref <= '0;
			prev <= '0;
		end else begin
			if (psel && penable && pwrite && paddr == 4'h0) begin
				flags_ref <= pwdata & FLAG_MASK;
			end
			if (ex_v && uop.cmps_first && !wb_stall) begin
				cmps_ref <= ops.a;
			end
			// follows the writeback latch and holds under stall
			if (!wb_stall) begin
				prev <= cur;
			end
		end
	end

	always_comb begin
		b_eff = uop.cmps_second ? cmps_ref : ops.b;
		step = 32'd1 << uop.dsize;
		sh = b_eff[4:0];
		signed_sum = '0;
		cur = '0;
		cur.uop = uop;
		cur.v = ex_v && !(uop.repne && saved_count == 32'h0);
		cur.a = ops.a;
		case (uop.aluk)
			ALU_ADD: begin
				{cur.alu_cf, cur.alu} = ops.a + b_eff;
				// signed overflow shows as a mismatch of the top two bits
				signed_sum = {ops.a[31], ops.a} + {b_eff[31], b_eff};
				cur.alu_of = signed_sum[32] != signed_sum[31];
			end
			ALU_SUB: begin
				cur.alu = ops.a - b_eff;
				cur.alu_cf = ops.a < b_eff;
				signed_sum = {ops.a[31], ops.a} - {b_eff[31], b_eff};
				cur.alu_of = signed_sum[32] != signed_sum[31];
			end
			ALU_AND: cur.alu = ops.a & b_eff;
			ALU_OR:  cur.alu = ops.a | b_eff;
			ALU_XOR: cur.alu = ops.a ^ b_eff;
			default: cur.alu = b_eff;
		endcase
		cur.zf = cur.alu == 32'h0;
		// CF is the last bit that left the word
		if (uop.aluk == ALU_SHR) begin
			cur.shift = ops.a >> sh;
			cur.shift_cf = (sh == 5'd0) ? flags_ref[FLAG_CF] : ops.a[sh - 1];
		end else begin
			cur.shift = ops.a << sh;
			cur.shift_cf = (sh == 5'd0) ? flags_ref[FLAG_CF] : ops.a[32 - sh];
		end
		cur.shift_op = (uop.aluk == ALU_SHL || uop.aluk == ALU_SHR) && !(uop.is_alu32 ||
			uop.alu32_flags || uop.mux_cmps_pointer || uop.cmps_first || uop.is_xchg ||
			uop.pass_a || uop.is_cmpxchg);
		cur.ptr = flags_ref[FLAG_DF] ? b_eff - step : b_eff + step;
		cur.cnt = (uop.repne ? saved_count : ops.c) - 32'h1;
		cur.pop = ops.c + step;
	end

	// ------------------------------------------------------------
	// writeback checks
	// ------------------------------------------------------------
	alu_lane_check: assert property (@(posedge CLK) disable iff (rst)
		prev.v && prev.uop.is_alu32 |-> wb_result.result_a == prev.alu &&
			(!prev.uop.alu32_flags || (wb_result.flags[FLAG_CF] == prev.alu_cf &&
			wb_result.flags[FLAG_ZF] == prev.zf && wb_result.flags[FLAG_SF] == prev.alu[31] &&
			wb_result.flags[FLAG_OF] == prev.alu_of)))
		else begin
			$error("alu result or flags differ from reference");
			fail_count++;
		end

	shift_lane_check: assert property (@(posedge CLK) disable iff (rst)
		prev.v && prev.shift_op |-> wb_result.result_a == prev.shift &&
			wb_result.flags[FLAG_CF] == prev.shift_cf &&
			wb_result.flags[FLAG_ZF] == (prev.shift == 32'h0))
		else begin
			$error("shift result or flags differ from reference");
			fail_count++;
		end

	cmps_check: assert property (@(posedge CLK) disable iff (rst)
		prev.v && (prev.uop.cmps_first || prev.uop.cmps_second) |->
			wb_result.result_c == prev.cnt &&
			(!prev.uop.mux_cmps_pointer || wb_result.result_b == prev.ptr))
		else begin
			$error("compare-string pointer or count wrong");
			fail_count++;
		end

	pop_check: assert property (@(posedge CLK) disable iff (rst)
		prev.v && prev.uop.mux_sp_pop && !prev.uop.cmps_first && !prev.uop.cmps_second |->
			wb_result.result_c == prev.pop)
		else begin
			$error("popped stack pointer wrong");
			fail_count++;
		end

	cmpxchg_check: assert property (@(posedge CLK) disable iff (rst)
		prev.v && prev.uop.is_cmpxchg |-> wb_result.result_b == prev.a &&
			wb_ctrl.ld_gpr1 == (prev.uop.ld_gpr1 && prev.zf) &&
			wb_ctrl.ld_gpr2 == !prev.zf &&
			wb_ctrl.dcache_write == (prev.uop.dcache_write && prev.zf))
		else begin
			$error("cmpxchg enables or lane b wrong");
			fail_count++;
		end

	// decoded enables pass through, qualified by v
	valid_check: assert property (@(posedge CLK) disable iff (rst)
		wb_ctrl.v == prev.v && ((prev.v && prev.uop.is_cmpxchg) ||
			(wb_ctrl.ld_gpr1 == (prev.v && prev.uop.ld_gpr1) &&
			wb_ctrl.ld_gpr2 == (prev.v && prev.uop.ld_gpr2) &&
			wb_ctrl.dcache_write == (prev.v && prev.uop.dcache_write))))
		else begin
			$error("writeback valid or its enables wrong");
			fail_count++;
		end

	stall_load_check: assert property (@(posedge CLK) disable iff (rst)
		wb_ld_latches == !wb_stall)
		else begin
			$error("latch load does not follow the stall input");
			fail_count++;
		end

	stall_hold_check: assert property (@(posedge CLK) disable iff (rst)
		wb_stall |=> $stable(wb_result) && $stable(wb_ctrl))
		else begin
			$error("writeback outputs moved during stall");
			fail_count++;
		end

endmodule

bind ex_stage ex_stage_assertions u_assertions (
	.CLK(CLK),
	.rst(rst),
	.ex_v(ex_v),
	.uop(uop),
	.ops(ops),
	.saved_count(saved_count),
	.wb_stall(wb_stall),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.paddr(paddr),
	.pwdata(pwdata),
	.wb_result(wb_result),
	.wb_ctrl(wb_ctrl),
	.wb_ld_latches(wb_ld_latches)
);

// File: tests/ex_stage_tb.sv
module ex_stage_tb import ex_uop_pkg::*, ex_result_pkg::*; ();

	localparam int PERIOD = 100;
	localparam int RESET_CYCLES = 16;
	localparam int RETIRE_W = 16;
	localparam int N_ALU = 40;
	localparam int N_SHIFT = 32;
	localparam int N_CMPXCHG = 16;
	localparam int N_REPNE = 16;
	localparam int STALL_CYCLES = 4;
	localparam int APB_CYCLES = 3;
	localparam int RUN_CYCLES = RESET_CYCLES + N_ALU + N_SHIFT + N_CMPXCHG + N_REPNE +
		3 * (STALL_CYCLES + 2) + 2 * (4 * 4 + 1) + 12 * APB_CYCLES + 7 * 2;
	localparam logic [3:0] ADDR_FLAGS = 4'h0;
	localparam logic [3:0] ADDR_RETIRED = 4'h4;
	localparam logic [3:0] ADDR_UNMAPPED = 4'h8;
	localparam logic [31:0] FLAG_MASK = (32'd1 << FLAG_CF) | (32'd1 << FLAG_AF) |
		(32'd1 << FLAG_DF);

	logic         CLK = 1'b0;
	logic         rst;
	logic         ex_v;
	ex_uop_t      uop;
	ex_operands_t ops;
	logic [31:0]  saved_count;
	logic         wb_stall;
	logic         psel;
	logic         penable;
	logic         pwrite;
	logic [3:0]   paddr;
	logic [31:0]  pwdata;
	logic [31:0]  prdata;
	logic         pready;
	wb_result_t   wb_result;
	wb_ctrl_t     wb_ctrl;
	logic         wb_ld_latches;

	integer seed = 32'h3e3;
	int     errors = 0;
	int     tests_run = 0;
	int     tests_failed = 0;
	int     valid_count = 0;
	int     errors_mark = 0;
	int     asserts_mark = 0;

	ex_stage #(.RETIRE_W(RETIRE_W)) ex_stage_i (
		.CLK(CLK), .rst(rst), .ex_v(ex_v), .uop(uop), .ops(ops),
		.saved_count(saved_count), .wb_stall(wb_stall), .psel(psel), .penable(penable),
		.pwrite(pwrite), .paddr(paddr), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.wb_result(wb_result), .wb_ctrl(wb_ctrl), .wb_ld_latches(wb_ld_latches)
	);

	initial begin
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		#(2 * RUN_CYCLES * PERIOD);
		$display("watchdog expired, the run did not finish in time");
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------
	function automatic ex_operands_t rand_ops();
		ex_operands_t o;
		o.a = $random(seed);
		o.b = $random(seed);
		o.c = $random(seed);
		return o;
	endfunction

	// a micro-op retires unless stalled or a repne with zero count
	task automatic issue_uop(input ex_uop_t u, input ex_operands_t o, input logic [31:0] cnt,
			input logic stall);
		@(negedge CLK);
		ex_v = 1'b1;
		uop = u;
		ops = o;
		saved_count = cnt;
		wb_stall = stall;
		if (!stall && !(u.repne && cnt == 32'h0)) begin
			valid_count++;
		end
	endtask

	task automatic go_idle();
		@(negedge CLK);
		ex_v = 1'b0;
		uop = '0;
		ops = '0;
		saved_count = '0;
		wb_stall = 1'b0;
	endtask

	task automatic wait_ready();
		int cycles;
		cycles = 0;
		while (!pready && cycles < 16) begin
			@(negedge CLK);
			cycles++;
		end
		if (!pready) begin
			$display("apb: pready stayed low for %0d cycles", cycles);
			errors++;
		end
		// access completes on the rising edge in between
		@(negedge CLK);
	endtask

	task automatic apb_access(input logic [3:0] addr, input logic write,
			input logic [31:0] wdata, output logic [31:0] rdata);
		@(negedge CLK);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge CLK);
		penable = 1'b1;
		wait_ready();
		rdata = prdata;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		apb_access(addr, 1'b1, data, unused);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	// drains the last micro-op so its checks land inside this test
	task automatic finish_test(input string name);
		int asserts_new;
		int errors_new;
		go_idle();
		@(negedge CLK);
		asserts_new = ex_stage_i.u_assertions.fail_count - asserts_mark;
		errors_new = errors - errors_mark;
		asserts_mark = ex_stage_i.u_assertions.fail_count;
		errors_mark = errors;
		tests_run++;
		if (asserts_new != 0) begin
			$display("[ERROR] %s: assertion failures expected 0 actual %0d", name, asserts_new);
		end
		if (asserts_new != 0 || errors_new != 0) begin
			tests_failed++;
			$display("%s: failed", name);
		end else begin
			$display("%s: passed", name);
		end
	endtask

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	task automatic run_alu_test();
		ex_uop_t u;
		ex_operands_t o;
		for (int i = 0; i < N_ALU; i++) begin
			u = '0;
			u.aluk = aluk_e'($unsigned($random(seed)) % 6);
			u.is_alu32 = 1'b1;
			u.alu32_flags = 1'b1;
			u.ld_gpr1 = 1'b1;
			o = rand_ops();
			// equal operands zero the result of sub and xor
			if (i % 4 == 0) begin
				o.b = o.a;
			end
			issue_uop(u, o, 32'h0, 1'b0);
		end
		finish_test("alu");
	endtask

	task automatic run_shift_test();
		ex_uop_t u;
		ex_operands_t o;
		// a zero shift count must keep this CF
		apb_write(ADDR_FLAGS, 32'd1 << FLAG_CF);
		for (int i = 0; i < N_SHIFT; i++) begin
			u = '0;
			u.aluk = ($random(seed) & 1) ? ALU_SHR : ALU_SHL;
			u.ld_gpr1 = 1'b1;
			o = rand_ops();
			if (i % 8 == 0) begin
				o.b = 32'h0;
			end
			issue_uop(u, o, 32'h0, 1'b0);
		end
		finish_test("shift");
	endtask

	task automatic run_string_test();
		ex_uop_t first;
		ex_uop_t second;
		ex_uop_t pop;
		for (int dir = 0; dir < 2; dir++) begin
			go_idle();
			apb_write(ADDR_FLAGS, 32'(dir) << FLAG_DF);
			for (int d = 0; d < 4; d++) begin
				first = '0;
				first.dsize = dsize_e'(d);
				first.aluk = ALU_SUB;
				first.cmps_first = 1'b1;
				first.ld_gpr1 = 1'b1;
				second = first;
				second.cmps_first = 1'b0;
				second.cmps_second = 1'b1;
				second.mux_cmps_pointer = 1'b1;
				second.alu32_flags = 1'b1;
				pop = '0;
				pop.dsize = dsize_e'(d);
				pop.mux_sp_pop = 1'b1;
				pop.pass_a = 1'b1;
				pop.ld_gpr2 = 1'b1;
				issue_uop(first, rand_ops(), 32'h0, 1'b0);
				// saved operand must survive a bubble
				if (d % 2 == 1) begin
					go_idle();
				end
				issue_uop(second, rand_ops(), 32'h0, 1'b0);
				issue_uop(pop, rand_ops(), 32'h0, 1'b0);
			end
		end
		finish_test("string");
	endtask

	task automatic run_cmpxchg_test();
		ex_uop_t u;
		ex_operands_t o;
		for (int i = 0; i < N_CMPXCHG; i++) begin
			u = '0;
			u.aluk = ALU_SUB;
			u.is_cmpxchg = 1'b1;
			u.alu32_flags = 1'b1;
			u.ld_gpr1 = 1'b1;
			u.dcache_write = 1'b1;
			o = rand_ops();
			if (i % 2 == 0) begin
				o.b = o.a;
			end
			issue_uop(u, o, 32'h0, 1'b0);
		end
		finish_test("cmpxchg");
	endtask

	task automatic run_repne_test();
		ex_uop_t u;
		logic [31:0] cnt;
		for (int i = 0; i < N_REPNE; i++) begin
			u = '0;
			u.aluk = ALU_SUB;
			u.repne = 1'b1;
			u.is_alu32 = 1'b1;
			u.alu32_flags = 1'b1;
			u.ld_gpr1 = 1'b1;
			u.ld_gpr2 = 1'b1;
			cnt = (i % 2 == 0) ? 32'h0 : ($random(seed) | 32'h1);
			issue_uop(u, rand_ops(), cnt, 1'b0);
		end
		finish_test("repne");
	endtask

	task automatic run_stall_test();
		ex_uop_t u;
		ex_operands_t o;
		for (int i = 0; i < 3; i++) begin
			u = '0;
			u.aluk = ALU_ADD;
			u.is_alu32 = 1'b1;
			u.alu32_flags = 1'b1;
			u.ld_gpr1 = 1'b1;
			issue_uop(u, rand_ops(), 32'h0, 1'b0);
			o = rand_ops();
			// upstream holds the micro-op until the stall clears
			repeat (STALL_CYCLES) issue_uop(u, o, 32'h0, 1'b1);
			issue_uop(u, o, 32'h0, 1'b0);
		end
		finish_test("stall");
	endtask

	task automatic run_apb_test();
		logic [31:0] rd;
		logic [31:0] wr;
		apb_write(ADDR_FLAGS, 32'hffff_ffff);
		apb_access(ADDR_FLAGS, 1'b0, 32'h0, rd);
		check_value("apb flags all ones", FLAG_MASK, rd);
		wr = $random(seed);
		apb_write(ADDR_FLAGS, wr);
		apb_access(ADDR_FLAGS, 1'b0, 32'h0, rd);
		check_value("apb flags random", wr & FLAG_MASK, rd);
		// counter is read-only
		apb_write(ADDR_RETIRED, 32'h1234);
		apb_access(ADDR_RETIRED, 1'b0, 32'h0, rd);
		check_value("apb retired count", 32'(valid_count), rd);
		apb_access(ADDR_UNMAPPED, 1'b0, 32'h0, rd);
		check_value("apb unmapped", 32'h0, rd);
		finish_test("apb");
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		int asserts_total;
		rst = 1'b1;
		ex_v = 1'b0;
		uop = '0;
		ops = '0;
		saved_count = '0;
		wb_stall = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (RESET_CYCLES) @(negedge CLK);
		rst = 1'b0;
		run_alu_test();
		run_shift_test();
		run_string_test();
		run_cmpxchg_test();
		run_repne_test();
		run_stall_test();
		run_apb_test();
		asserts_total = ex_stage_i.u_assertions.fail_count;
		$display("tests run %0d, failed %0d, value errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, asserts_total);
		if (tests_failed == 0 && errors == 0 && asserts_total == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule
